// File: sim/feed_stimulus.txt
# W addr c0..c7 | C pbs_id rot last_pbs | E d0 d1 d2 d3 flags (all hex except flags)
# flags are binary sob eob sol eol soc eoc; W addr is slot*4 + poly*2 + word
W 0 0100 0101 0102 0103 0104 0105 0106 0107
W 1 0108 0109 010A 010B 010C 010D 010E 010F
W 2 0200 0201 0202 0203 0204 0205 0206 0207
W 3 0208 0209 020A 020B 020C 020D 020E 020F
W 4 1100 1101 1102 1103 1104 1105 1106 1107
W 5 1108 1109 110A 110B 110C 110D 110E 110F
W 6 1200 1201 1202 1203 1204 1205 1206 1207
W 7 1208 1209 120A 120B 120C 120D 120E 120F
C 0 00 0
C 0 04 0
C 1 14 1
# slot 0, rot 0
E 0000 0000 0000 0000 101010
E 0000 0000 0000 0000 000001
E 0000 0000 0000 0000 000010
E 0000 0000 0000 0000 000101
E 0000 0000 0000 0000 000010
E 0000 0000 0000 0000 000001
E 0000 0000 0000 0000 000010
E 0000 0000 0000 0000 010101
# slot 0, rot 4
E FDF4 FDF2 FDF0 FDEE 101010
E FFFC FFFC FFFC FFFC 000001
E FFFC FFFC FFFC FFFC 000010
E FFFC FFFC FFFC FFFC 000101
E FBF4 FBF2 FBF0 FBEE 000010
E FFFC FFFC FFFC FFFC 000001
E FFFC FFFC FFFC FFFC 000010
E FFFC FFFC FFFC FFFC 010101
# slot 1, rot 20
E 000C 000C 000C 000C 101010
E DDFC DDFA DDF8 DDF6 000001
E DDF4 DDF2 DDF0 DDEE 000010
E DDEC DDEA DDE8 DDE6 000101
E 000C 000C 000C 000C 000010
E DBFC DBFA DBF8 DBF6 000001
E DBF4 DBF2 DBF0 DBEE 000010
E DBEC DBEA DBE8 DBE6 010101

// File: verilog.f
hdl/feed_pkg.sv
hdl/gram_bank.sv
hdl/feed_addr_cnt.sv
hdl/feed_seq_fsm.sv
hdl/rot_sub_feed.sv
hdl/feed_top.sv
sim/feed_assert.sv
sim/feed_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the feed testbench with Verilator, runs it and checks the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim_run.log

verilator --binary --timing --assert -f verilog.f --top-module feed_tb -o feed_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/feed_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation passed"
exit 0

// File: sim/feed_tb.sv
// Run from the project root so sim/feed_stimulus.txt opens; chunks are checked in command order
`timescale 1ns/1ns
module feed_tb;
  import feed_pkg::*;

  localparam int CHUNK_PER_CMD = GLWE_K_P1 * WORD_PER_POLY * CHUNK_NB;

  logic                           clk;
  logic                           s_rst_n;
  logic                           cmd_vld = 1'b0;
  rot_cmd_t                       cmd = '0;
  logic                           cmd_credit;
  logic                           out_credit = 1'b0;
  logic                           out_vld;
  acc_chunk_t                     out;
  logic                           gram_wr_en;
  gaddr_t                         gram_wr_addr;
  logic [COEF_PER_WORD-1:0][15:0] gram_wr_data;

  // Contents of the stimulus file
  gaddr_t                         wr_addr_q[$];
  logic [COEF_PER_WORD-1:0][15:0] wr_data_q[$];
  rot_cmd_t                       cmd_q[$];
  logic [ACC_COEF_NB-1:0][15:0]   exp_data_q[$];
  logic [5:0]                     exp_flag_q[$];

  int seed        = 32'h57e8_9d10;
  int errors      = 0;
  int rcv_cnt     = 0;
  int sent_cnt    = 0;
  int cmd_cred    = CMD_DEPTH;
  int out_owed    = 0;
  int cycle_cnt   = 0;
  int timeout_lim = 200;
  bit send_en     = 1'b0;
  bit load_ok;

  feed_top dut_i (
    .clk(clk), .s_rst_n(s_rst_n), .cmd_vld(cmd_vld), .cmd(cmd), .cmd_credit(cmd_credit),
    .out_credit(out_credit), .out_vld(out_vld), .out(out), .gram_wr_en(gram_wr_en),
    .gram_wr_addr(gram_wr_addr), .gram_wr_data(gram_wr_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  // ==================================================
  // Stimulus file
  // ==================================================
  task automatic load_stimulus(output bit ok);
    int          fd;
    int          n;
    string       line;
    gaddr_t      addr;
    logic [15:0] v [COEF_PER_WORD];
    logic [5:0]  fl;
    logic [1:0]  id;
    logic [4:0]  rt;
    logic        lp;
    rot_cmd_t    c;
    logic [COEF_PER_WORD-1:0][15:0] wd;
    logic [ACC_COEF_NB-1:0][15:0]   hw;
    ok = 1'b1;
    fd = $fopen("sim/feed_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file sim/feed_stimulus.txt");
      ok = 1'b0;
    end else begin
      while ($fgets(line, fd) != 0) begin
        n = 0;
        case (line[0])
          "W": begin
            n = $sscanf(line, "W %h %h %h %h %h %h %h %h %h", addr,
                        v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
            for (int i = 0; i < COEF_PER_WORD; i++) begin
              wd[i] = v[i];
            end
            wr_addr_q.push_back(addr);
            wr_data_q.push_back(wd);
            n = n - 9;
          end
          "C": begin
            n = $sscanf(line, "C %h %h %h", id, rt, lp);
            c.pbs_id   = id;
            c.rot      = rt;
            c.last_pbs = lp;
            cmd_q.push_back(c);
            n = n - 3;
          end
          "E": begin
            n = $sscanf(line, "E %h %h %h %h %b", v[0], v[1], v[2], v[3], fl);
            for (int i = 0; i < ACC_COEF_NB; i++) begin
              hw[i] = v[i];
            end
            exp_data_q.push_back(hw);
            exp_flag_q.push_back(fl);
            n = n - 5;
          end
          "#", " ", "\n", "\r": begin
          end
          default: n = -1;
        endcase
        if (n != 0) begin
          $display("Stimulus line could not be read: %s", line);
          ok = 1'b0;
        end
      end
      $fclose(fd);
    end
  endtask

  // Expected pbs_id and last_pbs come from the command that owns the chunk
  task automatic compare_chunk();
    rot_cmd_t exp_cmd;
    if (rcv_cnt >= exp_data_q.size()) begin
      errors++;
      $display("Unexpected extra chunk at %0t ns", $time);
    end else begin
      exp_cmd = cmd_q[rcv_cnt / CHUNK_PER_CMD];
      check_val("out.data", 64'(out.data), 64'(exp_data_q[rcv_cnt]));
      check_val("out.flags", 64'({out.sob, out.eob, out.sol, out.eol, out.soc, out.eoc}),
                64'(exp_flag_q[rcv_cnt]));
      check_val("out.pbs_id", 64'(out.pbs_id), 64'(exp_cmd.pbs_id));
      check_val("out.last_pbs", 64'(out.last_pbs), 64'(exp_cmd.last_pbs));
    end
    rcv_cnt++;
  endtask

  // ==================================================
  // Command sender, chunk monitor, credit return
  // ==================================================
  always @(negedge clk) begin
    int rnd;
    if (s_rst_n) begin
      // A credit seen now may be spent in the same cycle
      if (cmd_credit) begin
        cmd_cred++;
      end
      if (send_en && sent_cnt < cmd_q.size() && cmd_cred > 0) begin
        cmd_vld = 1'b1;
        cmd     = cmd_q[sent_cnt];
        sent_cnt++;
        cmd_cred--;
      end else begin
        cmd_vld = 1'b0;
      end
      if (out_vld) begin
        compare_chunk();
        out_owed++;
      end
      // Random back-pressure on the output
      rnd = $random(seed);
      if (out_owed > 0 && rnd[0]) begin
        out_credit = 1'b1;
        out_owed--;
      end else begin
        out_credit = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > timeout_lim) begin
      $display("Timeout after %0d cycles, errors: %0d, chunks: %0d of %0d",
               cycle_cnt, errors, rcv_cnt, exp_data_q.size());
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    s_rst_n      = 1'b0;
    gram_wr_en   = 1'b0;
    gram_wr_addr = '0;
    gram_wr_data = '0;
    load_stimulus(load_ok);
    timeout_lim = 40 * exp_data_q.size() + 200;
    if (!load_ok) begin
      $display("Stimulus file is missing or malformed, errors: %0d", errors);
      $display("TEST FAILED");
      $finish;
    end else begin
      repeat (2) @(negedge clk);
      s_rst_n = 1'b1;
      // GRAM fill while the feed is idle
      foreach (wr_addr_q[i]) begin
        gram_wr_en   = 1'b1;
        gram_wr_addr = wr_addr_q[i];
        gram_wr_data = wr_data_q[i];
        @(negedge clk);
      end
      gram_wr_en = 1'b0;
      send_en    = 1'b1;
      while (rcv_cnt < exp_data_q.size()) begin
        @(negedge clk);
      end
      // Late or duplicated chunks would show up here
      repeat (20) @(negedge clk);
      check_val("cmd_credits", 64'(cmd_cred), 64'(CMD_DEPTH));
      check_val("chunk_count", 64'(rcv_cnt), 64'(exp_data_q.size()));
      $display("Errors: %0d, chunks: %0d of %0d", errors, rcv_cnt, exp_data_q.size());
      if (errors == 0) begin
        $display("TEST OK");
      end else begin
        $display("TEST FAILED");
      end
      $finish;
    end
  end

endmodule

// File: sim/feed_assert.sv
// Both credit models assume full credits right after reset and one credit pulse per cycle at most
`timescale 1ns/1ns
module feed_assert (
  input logic                 clk,
  input logic                 s_rst_n,
  input logic                 cmd_vld,
  input logic                 cmd_credit,
  input logic                 out_vld,
  input logic                 out_credit,
  input feed_pkg::acc_chunk_t out
);
  import feed_pkg::*;

  logic [2:0] cmd_avail;
  logic [2:0] out_held;

  // ==================================================
  // Credit models
  // ==================================================
  // Free command slots seen by the sender, chunks not yet credited back
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      cmd_avail <= 3'(CMD_DEPTH);
      out_held  <= '0;
    end else begin
      cmd_avail <= cmd_avail - 3'(cmd_vld) + 3'(cmd_credit);
      out_held  <= out_held + 3'(out_vld) - 3'(out_credit);
    end
  end

  cmd_within_credit: assert property (@(posedge clk) disable iff (!s_rst_n)
    cmd_vld |-> (cmd_avail != '0 || cmd_credit))
    else $error("cmd_vld with no command credit left");

  out_within_credit: assert property (@(posedge clk) disable iff (!s_rst_n)
    out_vld |-> (out_held < 3'(OUT_CREDIT_MAX)))
    else $error("out_vld with no output credit left");

  // ==================================================
  // Chunk flags
  // ==================================================
  eoc_after_soc: assert property (@(posedge clk) disable iff (!s_rst_n)
    (out_vld && out.eoc) |-> $past(out_vld && out.soc))
    else $error("chunk 1 without chunk 0 just before it");

  soc_then_eoc: assert property (@(posedge clk) disable iff (!s_rst_n)
    (out_vld && out.soc) |=> (out_vld && out.eoc))
    else $error("chunk 1 does not follow chunk 0");

endmodule

bind feed_top feed_assert assert_i (
  .clk(clk), .s_rst_n(s_rst_n), .cmd_vld(cmd_vld), .cmd_credit(cmd_credit),
  .out_vld(out_vld), .out_credit(out_credit), .out(out)
);

// File: hdl/feed_top.sv
// GRAM writes are ignored while a command is being processed
`timescale 1ns/1ns
module feed_top (
  input  logic                                      clk,
  input  logic                                      s_rst_n,
  input  logic                                      cmd_vld,
  input  feed_pkg::rot_cmd_t                        cmd,
  output logic                                      cmd_credit,
  input  logic                                      out_credit,
  output logic                                      out_vld,
  output feed_pkg::acc_chunk_t                      out,
  input  logic                                      gram_wr_en,
  input  feed_pkg::gaddr_t                          gram_wr_addr,
  input  logic [feed_pkg::COEF_PER_WORD-1:0][15:0]  gram_wr_data
);
  import feed_pkg::*;

  logic       rd_go;
  logic       busy;
  logic       wr_ok;
  rot_cmd_t   act_cmd;
  rot_cmd_t   rd_cmd;
  gaddr_t     rd_addr;
  gaddr_t     rot_addr0;
  gaddr_t     rot_addr1;
  logic       perm_sel;
  rot_t       rot_base;
  logic       first_word;
  logic       last_word;
  logic       word_sol;
  logic       word_eol;
  logic       rd_last;
  half_word_t data [2];
  half_word_t rot_data [2];
  logic [1:0] vld;

  assign wr_ok = gram_wr_en && !busy;

  // Bank 0 holds coefficients 0-3, bank 1 holds 4-7
  gram_bank bank0_i (
    .clk(clk), .s_rst_n(s_rst_n),
    .wr_en(wr_ok), .wr_addr(gram_wr_addr), .wr_data(gram_wr_data[HALF_W-1:0]),
    .rd_en(rd_go), .rd_addr(rd_addr), .rd_data(data[0]),
    .rot_addr(rot_addr0), .rot_data(rot_data[0]), .rd_vld(vld[0])
  );

  gram_bank bank1_i (
    .clk(clk), .s_rst_n(s_rst_n),
    .wr_en(wr_ok), .wr_addr(gram_wr_addr), .wr_data(gram_wr_data[COEF_PER_WORD-1:HALF_W]),
    .rd_en(rd_go), .rd_addr(rd_addr), .rd_data(data[1]),
    .rot_addr(rot_addr1), .rot_data(rot_data[1]), .rd_vld(vld[1])
  );

  feed_addr_cnt addr_cnt_i (
    .clk(clk), .s_rst_n(s_rst_n), .rd_go(rd_go), .cmd(act_cmd),
    .rd_addr(rd_addr), .rot_addr0(rot_addr0), .rot_addr1(rot_addr1),
    .perm_sel(perm_sel), .rot_base(rot_base), .first_word(first_word),
    .last_word(last_word), .word_sol(word_sol), .word_eol(word_eol),
    .rd_cmd(rd_cmd), .rd_last(rd_last)
  );

  feed_seq_fsm seq_fsm_i (
    .clk(clk), .s_rst_n(s_rst_n), .cmd_vld(cmd_vld), .cmd(cmd),
    .cmd_credit(cmd_credit), .out_credit(out_credit), .chunk_sent(out_vld),
    .last_word(last_word), .rd_go(rd_go), .act_cmd(act_cmd), .busy(busy)
  );

  rot_sub_feed rot_sub_i (
    .clk(clk), .s_rst_n(s_rst_n), .in_vld(vld[0] && vld[1]),
    .in_data0(data[0]), .in_data1(data[1]), .in_rot0(rot_data[0]), .in_rot1(rot_data[1]),
    .in_perm_sel(perm_sel), .in_rot_base(rot_base), .in_cmd(rd_cmd),
    .in_sol(word_sol), .in_eol(word_eol), .in_first(first_word), .in_last(rd_last),
    .out_vld(out_vld), .out(out)
  );

endmodule

// File: hdl/rot_sub_feed.sv
// Input word and flags must stay stable for two cycles after in_vld; results are modulo 2^16
`timescale 1ns/1ns
module rot_sub_feed (
  input  logic                 clk,
  input  logic                 s_rst_n,
  input  logic                 in_vld,
  input  feed_pkg::half_word_t in_data0,
  input  feed_pkg::half_word_t in_data1,
  input  feed_pkg::half_word_t in_rot0,
  input  feed_pkg::half_word_t in_rot1,
  input  logic                 in_perm_sel,
  input  feed_pkg::rot_t       in_rot_base,
  input  feed_pkg::rot_cmd_t   in_cmd,
  input  logic                 in_sol,
  input  logic                 in_eol,
  input  logic                 in_first,
  input  logic                 in_last,
  output logic                 out_vld,
  output feed_pkg::acc_chunk_t out
);
  import feed_pkg::*;

  // ==================================================
  // S2 permutation and chunk select
  // ==================================================
  half_word_t perm0;
  half_word_t perm1;
  logic       chk;
  logic       ctrl_vld;
  half_word_t chk_data;
  half_word_t chk_rot;
  half_word_t chk_opp;
  logic [ACC_COEF_NB-1:0] chk_sign;

  assign perm0 = in_perm_sel ? in_rot1 : in_rot0;
  assign perm1 = in_perm_sel ? in_rot0 : in_rot1;

  // Chunk counter runs alone once started
  assign ctrl_vld = in_vld || chk;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      chk <= 1'b0;
    end else if (ctrl_vld) begin
      chk <= ~chk;
    end
  end

  assign chk_data = chk ? in_data1 : in_data0;
  assign chk_rot  = chk ? perm1 : perm0;

  always_comb begin
    rot_t t;
    for (int i = 0; i < ACC_COEF_NB; i++) begin
      // Rotated index at or above N takes the negacyclic sign
      t           = in_rot_base + rot_t'({chk, 2'b00}) + rot_t'(i);
      chk_sign[i] = t[4];
      chk_opp[i]  = coef_t'(0) - chk_data[i];
    end
  end

  // ==================================================
  // S3 and subtraction
  // ==================================================
  half_word_t             s3_rot;
  logic [ACC_COEF_NB-1:0] s3_sign;
  logic                   s3_vld;
  acc_chunk_t             s3_ctl;
  half_word_t             s3_sub;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      s3_vld <= 1'b0;
    end else begin
      s3_vld <= ctrl_vld;
    end
  end

  // Negated original data rides in the data field of the control word
  always_ff @(posedge clk) begin
    s3_rot          <= chk_rot;
    s3_sign         <= chk_sign;
    s3_ctl.data     <= chk_opp;
    s3_ctl.soc      <= !chk;
    s3_ctl.eoc      <= chk;
    s3_ctl.sol      <= in_sol && !chk;
    s3_ctl.eol      <= in_eol && chk;
    s3_ctl.sob      <= in_first && !chk;
    s3_ctl.eob      <= in_last && chk;
    s3_ctl.pbs_id   <= in_cmd.pbs_id;
    s3_ctl.last_pbs <= in_cmd.last_pbs;
  end

  always_comb begin
    for (int i = 0; i < ACC_COEF_NB; i++) begin
      s3_sub[i] = s3_sign[i] ? s3_ctl.data[i] - s3_rot[i] : s3_ctl.data[i] + s3_rot[i];
    end
  end

  // ==================================================
  // Output
  // ==================================================
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      out_vld <= 1'b0;
    end else begin
      out_vld <= s3_vld;
    end
  end

  always_ff @(posedge clk) begin
    out      <= s3_ctl;
    out.data <= s3_sub;
  end

endmodule

// File: hdl/feed_seq_fsm.sv
// Sender must honor cmd credits; out_credit is at most one pulse per consumed chunk
`timescale 1ns/1ns
module feed_seq_fsm (
  input  logic               clk,
  input  logic               s_rst_n,
  input  logic               cmd_vld,
  input  feed_pkg::rot_cmd_t cmd,
  output logic               cmd_credit,
  input  logic               out_credit,
  input  logic               chunk_sent,
  input  logic               last_word,
  output logic               rd_go,
  output feed_pkg::rot_cmd_t act_cmd,
  output logic               busy
);
  import feed_pkg::*;

  rot_cmd_t    store [CMD_DEPTH];
  logic        wr_ptr;
  logic        rd_ptr;
  logic [1:0]  cnt;
  logic [1:0]  cnt_n;
  logic        pop;
  logic        gap;
  credit_t     out_cred;
  credit_t     inflight;
  feed_state_e state;

  // ==================================================
  // Command store
  // ==================================================
  assign pop     = rd_go && last_word;
  assign cnt_n   = cnt + 2'(cmd_vld) - 2'(pop);
  assign act_cmd = store[rd_ptr];

  always_ff @(posedge clk) begin
    if (cmd_vld) begin
      store[wr_ptr] <= cmd;
    end
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      wr_ptr     <= 1'b0;
      rd_ptr     <= 1'b0;
      cnt        <= '0;
      cmd_credit <= 1'b0;
    end else begin
      wr_ptr     <= wr_ptr ^ cmd_vld;
      rd_ptr     <= rd_ptr ^ pop;
      cnt        <= cnt_n;
      cmd_credit <= pop;
    end
  end

  // ==================================================
  // Read pacing and credits
  // ==================================================
  // One word per two cycles, two credits reserved per word
  assign rd_go = (state == READ) && (cnt != 2'd0) && !gap && (out_cred >= credit_t'(CHUNK_NB));

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      gap      <= 1'b0;
      out_cred <= credit_t'(OUT_CREDIT_MAX);
      inflight <= '0;
    end else begin
      gap      <= rd_go;
      out_cred <= out_cred + credit_t'(out_credit) - (rd_go ? credit_t'(CHUNK_NB) : '0);
      inflight <= inflight + (rd_go ? credit_t'(CHUNK_NB) : '0) - credit_t'(chunk_sent);
    end
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (cnt != 2'd0) begin
            state <= READ;
          end
        end
        READ: begin
          if (pop && cnt_n == 2'd0) begin
            state <= DRAIN;
          end
        end
        DRAIN: begin
          if (cnt != 2'd0) begin
            state <= READ;
          end else if (inflight == '0) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign busy = (state != IDLE);

endmodule

// File: hdl/feed_addr_cnt.sv
// Rotation must be a multiple of 4; addresses are combinational, position flags lag by one cycle
`timescale 1ns/1ns
module feed_addr_cnt (
  input  logic               clk,
  input  logic               s_rst_n,
  input  logic               rd_go,
  input  feed_pkg::rot_cmd_t cmd,
  output feed_pkg::gaddr_t   rd_addr,
  output feed_pkg::gaddr_t   rot_addr0,
  output feed_pkg::gaddr_t   rot_addr1,
  output logic               perm_sel,
  output feed_pkg::rot_t     rot_base,
  output logic               first_word,
  output logic               last_word,
  output logic               word_sol,
  output logic               word_eol,
  output feed_pkg::rot_cmd_t rd_cmd,
  output logic               rd_last
);
  import feed_pkg::*;

  logic       word;
  logic       poly;
  logic       poly_end;
  rot_t       start;
  logic [3:0] src0;
  logic [3:0] src1;
  logic       swap;

  assign poly_end  = (word == 1'(WORD_PER_POLY - 1));
  assign last_word = poly_end && (poly == 1'(GLWE_K_P1 - 1));

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      word <= 1'b0;
      poly <= 1'b0;
    end else if (rd_go) begin
      word <= ~word;
      // Wraps to poly 0 at the end of the command
      if (poly_end) begin
        poly <= ~poly;
      end
    end
  end

  // First source position of the word, then reduced modulo N
  assign start = rot_t'(word) * rot_t'(COEF_PER_WORD) - cmd.rot;
  assign src0  = start[3:0];
  assign src1  = src0 + 4'(HALF_W);
  assign swap  = src0[2];

  assign rd_addr   = {cmd.pbs_id, poly, word};
  assign rot_addr0 = {cmd.pbs_id, poly, swap ? src1[3] : src0[3]};
  assign rot_addr1 = {cmd.pbs_id, poly, swap ? src0[3] : src1[3]};

  // ==================================================
  // Align with the bank read latency
  // ==================================================
  always_ff @(posedge clk) begin
    if (rd_go) begin
      perm_sel   <= swap;
      rot_base   <= start;
      first_word <= (word == 1'b0) && (poly == 1'b0);
      word_sol   <= (word == 1'b0) && (poly == 1'b0);
      word_eol   <= poly_end;
      rd_last    <= last_word;
      rd_cmd     <= cmd;
    end
  end

endmodule

// File: hdl/gram_bank.sv
// One GRAM bank of 16 half words; read data holds until the next rd_en, no read-during-write bypass
`timescale 1ns/1ns
module gram_bank (
  input  logic                 clk,
  input  logic                 s_rst_n,
  input  logic                 wr_en,
  input  feed_pkg::gaddr_t     wr_addr,
  input  feed_pkg::half_word_t wr_data,
  input  logic                 rd_en,
  input  feed_pkg::gaddr_t     rd_addr,
  output feed_pkg::half_word_t rd_data,
  input  feed_pkg::gaddr_t     rot_addr,
  output feed_pkg::half_word_t rot_data,
  output logic                 rd_vld
);
  import feed_pkg::*;

  half_word_t mem [BANK_DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Plain and rotated ports share the enable
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data  <= mem[rd_addr];
      rot_data <= mem[rot_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      rd_vld <= 1'b0;
    end else begin
      rd_vld <= rd_en;
    end
  end

endmodule

// File: hdl/feed_pkg.sv
// Sizes are fixed for N=16 with 2 polynomials per ciphertext and rotations that are multiples of 4
package feed_pkg;

  // ==================================================
  // Sizes
  // ==================================================
  localparam int N              = 16;
  localparam int COEF_PER_WORD  = 8;
  localparam int HALF_W         = COEF_PER_WORD / 2;
  localparam int CHUNK_NB       = 2;
  localparam int ACC_COEF_NB    = 4;
  localparam int GLWE_K_P1      = 2;
  localparam int WORD_PER_POLY  = 2;
  localparam int SLOT_NB        = 4;
  localparam int BANK_DEPTH     = SLOT_NB * GLWE_K_P1 * WORD_PER_POLY;
  localparam int CMD_DEPTH      = 2;
  localparam int OUT_CREDIT_MAX = 4;

  // ==================================================
  // Vector types
  // ==================================================
  typedef logic [15:0]                    coef_t;
  typedef logic [4:0]                     rot_t;
  typedef logic [1:0]                     slot_t;
  typedef logic [3:0]                     gaddr_t;
  typedef logic [2:0]                     credit_t;
  typedef logic [HALF_W-1:0][15:0]        half_word_t;

  // Command from the sequencer
  typedef struct packed {
    slot_t pbs_id;
    rot_t  rot;
    logic  last_pbs;
  } rot_cmd_t;

  // Chunk toward the decomposer
  typedef struct packed {
    logic [ACC_COEF_NB-1:0][15:0] data;
    logic                         sob;
    logic                         eob;
    logic                         sol;
    logic                         eol;
    logic                         soc;
    logic                         eoc;
    slot_t                        pbs_id;
    logic                         last_pbs;
  } acc_chunk_t;

  typedef enum logic [1:0] {
    IDLE,
    READ,
    DRAIN
  } feed_state_e;

endpackage
